// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Address and data field widths
    localparam int WORD_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFFSET_W       = 2;
    localparam int INDEX_W        = 1;
    localparam int TAG_W          = 12;

    // Bit 0 is the byte within a word, so the offset starts at bit 1
    localparam int OFFSET_LSB = 1;
    localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

    localparam int NUM_SETS = 1 << INDEX_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_READ,
        MEM_WRITE,
        WAIT_POSTED
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/100ps
`default_nettype none

module cache_way
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    // Lookup port
    input  index_t i_lookup_index,
    input  tag_t   i_lookup_tag,
    // Write port
    input  logic   i_wr_en,
    input  index_t i_wr_index,
    input  tag_t   i_wr_tag,
    input  line_t  i_wr_line,
    input  logic   i_wr_valid,
    // Lookup result
    output logic   o_hit,
    output logic   o_valid,
    output line_t  o_line
);

    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_q  [NUM_SETS];
    line_t               line_q [NUM_SETS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= i_wr_valid;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_q[i_wr_index]  <= i_wr_tag;
            line_q[i_wr_index] <= i_wr_line;
        end
    end

    assign o_valid = valid_q[i_lookup_index];
    assign o_line  = line_q[i_lookup_index];
    assign o_hit   = o_valid && (tag_q[i_lookup_index] == i_lookup_tag);

endmodule

`default_nettype wire

// File: cache_way_select.sv
`timescale 1ns/100ps
`default_nettype none

module cache_way_select
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = $clog2(NUM_WAYS)
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    // From the ways
    input  logic  [NUM_WAYS-1:0]         i_hit,
    input  logic  [NUM_WAYS-1:0]         i_valid,
    input  line_t [NUM_WAYS-1:0]         i_lines,
    // From the controller
    input  index_t                       i_index,
    input  offset_t                      i_offset,
    input  logic                         i_touch,
    input  logic  [WAY_W-1:0]            i_touch_way,
    // Merged results
    output logic                         o_hit_any,
    output logic  [WAY_W-1:0]            o_hit_way,
    output line_t                        o_hit_line,
    output word_t                        o_word,
    output logic  [WAY_W-1:0]            o_victim_way
);

    localparam logic [WAY_W-1:0] OLDEST = WAY_W'(NUM_WAYS - 1);

    // Age 0 is most recent
    logic [WAY_W-1:0] age [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0] touch_age;
    logic             victim_found;

    // At most one way hits
    always_comb begin
        o_hit_any  = 1'b0;
        o_hit_way  = '0;
        o_hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_hit[w]) begin
                o_hit_any  = 1'b1;
                o_hit_way  = WAY_W'(w);
                o_hit_line = i_lines[w];
            end
        end
    end

    assign o_word = o_hit_line[i_offset*WORD_W +: WORD_W];

    // Lowest invalid way first, else the oldest
    always_comb begin
        victim_found = 1'b0;
        o_victim_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!i_valid[w] && !victim_found) begin
                victim_found = 1'b1;
                o_victim_way = WAY_W'(w);
            end
        end
        if (!victim_found) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (age[i_index][w] == OLDEST) begin
                    o_victim_way = WAY_W'(w);
                end
            end
        end
    end

    assign touch_age = age[i_index][i_touch_way];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age[s][w] <= WAY_W'(w);
                end
            end
        end else if (i_touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == i_touch_way) begin
                    age[i_index][w] <= '0;
                end else if (age[i_index][w] < touch_age) begin
                    age[i_index][w] <= age[i_index][w] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = $clog2(NUM_WAYS)
) (
    input  logic                clk,
    input  logic                i_rst_n,
    // Processor side
    input  logic                i_read,
    input  logic                i_write,
    input  word_t               i_addr,
    input  word_t               i_wdata,
    output word_t               o_rdata,
    output logic                o_ready,
    // Memory side
    output logic                o_mem_read,
    output logic                o_mem_write,
    output word_t               o_mem_addr,
    output logic                o_mem_line,
    output line_t               o_mem_wdata,
    input  line_t               i_mem_rdata,
    input  logic                i_mem_ready,
    // Way array control
    output index_t              o_lookup_index,
    output tag_t                o_lookup_tag,
    output logic [NUM_WAYS-1:0] o_way_wr,
    output index_t              o_wr_index,
    output tag_t                o_wr_tag,
    output line_t               o_wr_line,
    output logic                o_wr_valid,
    // Selector results
    input  logic                i_hit_any,
    input  logic [WAY_W-1:0]    i_hit_way,
    input  line_t               i_hit_line,
    input  word_t               i_word,
    input  logic [WAY_W-1:0]    i_victim_way,
    // LRU update and word select
    output logic                o_touch,
    output logic [WAY_W-1:0]    o_touch_way,
    output offset_t             o_offset
);

    ctrl_state_t state;

    word_t   req_addr;
    word_t   req_wdata;
    logic    req_write;
    logic    pending;

    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    word_t   aligned_addr;

    logic    accept;
    logic    need_mem;
    logic    hold_for_post;
    line_t   merged_line;
    word_t   fill_word;

    assign req_tag      = req_addr[TAG_LSB +: TAG_W];
    assign req_index    = req_addr[INDEX_LSB +: INDEX_W];
    assign req_offset   = req_addr[OFFSET_LSB +: OFFSET_W];
    assign aligned_addr = {req_addr[WORD_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};

    assign o_ready = (state == IDLE);
    assign accept  = o_ready && (i_read ^ i_write);

    // Writes and misses both have to go out to memory
    assign need_mem      = req_write || !i_hit_any;
    assign hold_for_post = need_mem && pending;

    assign o_lookup_index = req_index;
    assign o_lookup_tag   = req_tag;
    assign o_offset       = req_offset;

    // Hit line with the new word dropped in
    always_comb begin
        merged_line = i_hit_line;
        merged_line[req_offset*WORD_W +: WORD_W] = req_wdata;
    end

    assign fill_word = i_mem_rdata[req_offset*WORD_W +: WORD_W];

    // Way write and LRU touch for write hits and fills
    assign o_wr_index = req_index;
    assign o_wr_tag   = req_tag;
    assign o_wr_valid = 1'b1;

    always_comb begin
        o_way_wr    = '0;
        o_wr_line   = merged_line;
        o_touch     = 1'b0;
        o_touch_way = i_hit_way;
        if (state == LOOKUP && i_hit_any && !hold_for_post) begin
            o_touch = 1'b1;
            if (req_write) begin
                o_way_wr[i_hit_way] = 1'b1;
            end
        end else if (state == MEM_READ && i_mem_ready) begin
            o_way_wr[i_victim_way] = 1'b1;
            o_wr_line              = i_mem_rdata;
            o_touch                = 1'b1;
            o_touch_way            = i_victim_way;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= IDLE;
            req_write   <= 1'b0;
            pending     <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_mem_line  <= 1'b0;
        end else begin
            // Posted line write retires whatever state we are in
            if (pending && i_mem_ready) begin
                pending     <= 1'b0;
                o_mem_write <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (accept) begin
                        req_write <= i_write;
                        state     <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hold_for_post) begin
                        state <= WAIT_POSTED;
                    end else if (!req_write && i_hit_any) begin
                        state <= IDLE;
                    end else if (!req_write) begin
                        o_mem_read <= 1'b1;
                        o_mem_line <= 1'b1;
                        state      <= MEM_READ;
                    end else if (i_hit_any) begin
                        // Post the line write and let the processor go on
                        o_mem_write <= 1'b1;
                        o_mem_line  <= 1'b1;
                        pending     <= 1'b1;
                        state       <= IDLE;
                    end else begin
                        o_mem_write <= 1'b1;
                        o_mem_line  <= 1'b0;
                        state       <= MEM_WRITE;
                    end
                end
                MEM_READ: begin
                    if (i_mem_ready) begin
                        o_mem_read <= 1'b0;
                        state      <= IDLE;
                    end
                end
                MEM_WRITE: begin
                    if (i_mem_ready) begin
                        o_mem_write <= 1'b0;
                        state       <= IDLE;
                    end
                end
                WAIT_POSTED: begin
                    // Look up again once the bus is free
                    if (i_mem_ready || !pending) begin
                        state <= LOOKUP;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request, read data and memory payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
        end
        if (state == LOOKUP && !hold_for_post) begin
            if (!req_write && i_hit_any) begin
                o_rdata <= i_word;
            end else if (!req_write) begin
                o_mem_addr <= aligned_addr;
            end else if (i_hit_any) begin
                o_mem_addr  <= aligned_addr;
                o_mem_wdata <= merged_line;
            end else begin
                // Single word in the low bits
                o_mem_addr  <= req_addr;
                o_mem_wdata <= {{(LINE_W-WORD_W){1'b0}}, req_wdata};
            end
        end
        if (state == MEM_READ && i_mem_ready) begin
            o_rdata <= fill_word;
        end
    end

endmodule

`default_nettype wire

// File: cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = $clog2(NUM_WAYS)
) (
    input  logic  clk,
    input  logic  i_rst_n,
    // Processor side
    input  logic  i_read,
    input  logic  i_write,
    input  word_t i_addr,
    input  word_t i_wdata,
    output word_t o_rdata,
    output logic  o_ready,
    // Memory side
    output logic  o_mem_read,
    output logic  o_mem_write,
    output word_t o_mem_addr,
    output logic  o_mem_line,
    output line_t o_mem_wdata,
    input  line_t i_mem_rdata,
    input  logic  i_mem_ready
);

    index_t                lookup_index;
    tag_t                  lookup_tag;
    logic [NUM_WAYS-1:0]   way_wr;
    index_t                wr_index;
    tag_t                  wr_tag;
    line_t                 wr_line;
    logic                  wr_valid;

    logic  [NUM_WAYS-1:0]  way_hit;
    logic  [NUM_WAYS-1:0]  way_valid;
    line_t [NUM_WAYS-1:0]  way_lines;

    logic                  hit_any;
    logic [WAY_W-1:0]      hit_way;
    line_t                 hit_line;
    word_t                 sel_word;
    logic [WAY_W-1:0]      victim_way;
    logic                  touch;
    logic [WAY_W-1:0]      touch_way;
    offset_t               offset;

    cache_ctrl #(
        .NUM_WAYS(NUM_WAYS)
    ) i_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .o_rdata        (o_rdata),
        .o_ready        (o_ready),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_addr     (o_mem_addr),
        .o_mem_line     (o_mem_line),
        .o_mem_wdata    (o_mem_wdata),
        .i_mem_rdata    (i_mem_rdata),
        .i_mem_ready    (i_mem_ready),
        .o_lookup_index (lookup_index),
        .o_lookup_tag   (lookup_tag),
        .o_way_wr       (way_wr),
        .o_wr_index     (wr_index),
        .o_wr_tag       (wr_tag),
        .o_wr_line      (wr_line),
        .o_wr_valid     (wr_valid),
        .i_hit_any      (hit_any),
        .i_hit_way      (hit_way),
        .i_hit_line     (hit_line),
        .i_word         (sel_word),
        .i_victim_way   (victim_way),
        .o_touch        (touch),
        .o_touch_way    (touch_way),
        .o_offset       (offset)
    );

    // One storage block per way
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        cache_way i_way (
            .clk            (clk),
            .i_rst_n        (i_rst_n),
            .i_lookup_index (lookup_index),
            .i_lookup_tag   (lookup_tag),
            .i_wr_en        (way_wr[g]),
            .i_wr_index     (wr_index),
            .i_wr_tag       (wr_tag),
            .i_wr_line      (wr_line),
            .i_wr_valid     (wr_valid),
            .o_hit          (way_hit[g]),
            .o_valid        (way_valid[g]),
            .o_line         (way_lines[g])
        );
    end

    cache_way_select #(
        .NUM_WAYS(NUM_WAYS)
    ) i_select (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_hit        (way_hit),
        .i_valid      (way_valid),
        .i_lines      (way_lines),
        .i_index      (lookup_index),
        .i_offset     (offset),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .o_hit_any    (hit_any),
        .o_hit_way    (hit_way),
        .o_hit_line   (hit_line),
        .o_word       (sel_word),
        .o_victim_way (victim_way)
    );

endmodule

`default_nettype wire

// File: cache_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cache_properties
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_ready,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  word_t       i_mem_addr,
    input  logic        i_mem_line,
    input  line_t       i_mem_wdata,
    input  logic        i_mem_ready
);

    int assert_errors = 0;

    // One memory request at a time
    a_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_mem_read && i_mem_write))
        else begin
            $error("memory read and write requests are both high");
            assert_errors++;
        end

    a_read_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mem_read && !i_mem_ready) |=>
            (i_mem_read && $stable(i_mem_addr) && $stable(i_mem_line)))
        else begin
            $error("memory read request changed before i_mem_ready");
            assert_errors++;
        end

    // Write payload must also hold
    a_write_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mem_write && !i_mem_ready) |=>
            (i_mem_write && $stable(i_mem_addr) && $stable(i_mem_line)
             && $stable(i_mem_wdata)))
        else begin
            $error("memory write request changed before i_mem_ready");
            assert_errors++;
        end

    // Line reads and single word writes hold off the processor
    a_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mem_read || (i_mem_write && !i_mem_line)) |-> !i_ready)
        else begin
            $error("o_ready high while waiting on memory");
            assert_errors++;
        end

endmodule

bind cache_ctrl cache_properties i_props (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_ready     (o_ready),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write),
    .i_mem_addr  (o_mem_addr),
    .i_mem_line  (o_mem_line),
    .i_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready)
);

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #4 o_clk = ~o_clk;
        end
    end

    // Reset held low for the first 4 cycles
    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache
    import cache_pkg::*;
();

    localparam int NUM_WAYS     = 2;
    localparam int NUM_REQ      = 400;
    localparam int WORST_CYCLES = 24;
    localparam int MEM_WORDS    = 32768;

    logic  clk;
    logic  rst_n;
    logic  rd;
    logic  wr;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  ready;
    logic  mem_read;
    logic  mem_write;
    word_t mem_addr;
    logic  mem_line;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_ready;

    int seed = 32'h4868_78cb;
    int word_errors = 0;
    int line_errors = 0;
    int addr_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int done_count = 0;

    // Memory model contents and the expected view seen by the processor
    word_t mem     [MEM_WORDS];
    word_t ref_mem [MEM_WORDS];

    // Reference cache state
    logic  m_valid [NUM_SETS][NUM_WAYS];
    tag_t  m_tag   [NUM_SETS][NUM_WAYS];
    int    m_age   [NUM_SETS][NUM_WAYS];

    // Expected and observed memory requests
    logic  exp_write [$];
    word_t exp_addr  [$];
    logic  exp_line  [$];
    line_t exp_wdata [$];
    logic  act_write [$];
    word_t act_addr  [$];
    logic  act_line  [$];
    line_t act_wdata [$];

    tb_clk_gen i_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    cache_top #(
        .NUM_WAYS(NUM_WAYS)
    ) i_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_read      (rd),
        .i_write     (wr),
        .i_addr      (addr),
        .i_wdata     (wdata),
        .o_rdata     (rdata),
        .o_ready     (ready),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_mem_addr  (mem_addr),
        .o_mem_line  (mem_line),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata),
        .i_mem_ready (mem_ready)
    );

    function automatic word_t fill_value(int a);
        return word_t'((a * 40503) ^ (a >> 7) ^ 16'h3c5a);
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            line_errors++;
        end
    endtask

    task automatic check_addr(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    // Pair off memory requests seen so far with the predicted ones
    task automatic compare_traffic();
        while (exp_addr.size() > 0 && act_addr.size() > 0) begin
            check_flag("o_mem_write", act_write.pop_front(), exp_write.pop_front());
            check_flag("o_mem_line", act_line.pop_front(), exp_line.pop_front());
            check_addr("o_mem_addr", act_addr.pop_front(), exp_addr.pop_front());
            check_line("o_mem_wdata", act_wdata.pop_front(), exp_wdata.pop_front());
        end
    endtask

    // Most recent way gets age 0, younger ways age by one
    task automatic touch_way(int s, int w);
        int old_age;
        old_age = m_age[s][w];
        for (int k = 0; k < NUM_WAYS; k++) begin
            if (k == w) begin
                m_age[s][k] = 0;
            end else if (m_age[s][k] < old_age) begin
                m_age[s][k]++;
            end
        end
    endtask

    function automatic int pick_victim(int s);
        for (int k = 0; k < NUM_WAYS; k++) begin
            if (!m_valid[s][k]) begin
                return k;
            end
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            if (m_age[s][k] == NUM_WAYS - 1) begin
                return k;
            end
        end
        return 0;
    endfunction

    // Memory model answering after 1 to 6 cycles
    initial begin
        int delay;
        int a;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && (mem_read || mem_write)) begin
                act_write.push_back(mem_write);
                act_addr.push_back(mem_addr);
                act_line.push_back(mem_line);
                act_wdata.push_back(mem_write ? mem_wdata : '0);
                delay = 1 + int'($unsigned($random(seed)) % 32'd6);
                repeat (delay) @(posedge clk);
                #2;
                a = int'(mem_addr[15:1]);
                if (mem_write && mem_line) begin
                    for (int k = 0; k < WORDS_PER_LINE; k++) begin
                        mem[a + k] = mem_wdata[k*WORD_W +: WORD_W];
                    end
                end else if (mem_write) begin
                    mem[a] = mem_wdata[WORD_W-1:0];
                end else begin
                    for (int k = 0; k < WORDS_PER_LINE; k++) begin
                        mem_rdata[k*WORD_W +: WORD_W] = mem[a + k];
                    end
                end
                mem_ready = 1'b1;
                done_count++;
                @(posedge clk);
                #2;
                mem_ready = 1'b0;
            end
        end
    end

    // Watchdog sized from the request count
    initial begin
        #((NUM_REQ * WORST_CYCLES + 200) * 8);
        $display("Watchdog expired: the DUT stopped answering requests");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic  is_write;
        logic  hit;
        logic  free;
        int    s;
        int    w;
        int    cycles;
        int    done0;
        word_t aligned;
        tag_t  t;
        line_t ln;

        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        wdata = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_value(a);
            ref_mem[a] = fill_value(a);
        end
        for (int i = 0; i < NUM_SETS; i++) begin
            for (int k = 0; k < NUM_WAYS; k++) begin
                m_valid[i][k] = 1'b0;
                m_age[i][k] = k;
            end
        end

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_flag("o_ready", ready, 1'b1);
        check_flag("o_mem_read", mem_read, 1'b0);
        check_flag("o_mem_write", mem_write, 1'b0);

        for (int n = 0; n < NUM_REQ; n++) begin
            is_write = ($unsigned($random(seed)) % 32'd8) < 32'd3;
            addr = word_t'($random(seed)) & 16'h007e;
            wdata = word_t'($random(seed));
            aligned = addr & 16'hfff8;
            s = int'(addr[INDEX_LSB +: INDEX_W]);
            t = addr[TAG_LSB +: TAG_W];
            hit = 1'b0;
            w = 0;
            for (int k = 0; k < NUM_WAYS; k++) begin
                if (m_valid[s][k] && m_tag[s][k] == t) begin
                    hit = 1'b1;
                    w = k;
                end
            end
            rd = !is_write;
            wr = is_write;
            @(posedge clk);
            #1;
            rd = 1'b0;
            wr = 1'b0;
            // No posted write still open when the lookup runs
            free = !mem_read && !mem_write;
            done0 = done_count;

            if (is_write) begin
                ref_mem[int'(addr[15:1])] = wdata;
                if (hit) begin
                    for (int k = 0; k < WORDS_PER_LINE; k++) begin
                        ln[k*WORD_W +: WORD_W] = ref_mem[int'(aligned[15:1]) + k];
                    end
                    exp_line.push_back(1'b1);
                    exp_addr.push_back(aligned);
                    exp_wdata.push_back(ln);
                    touch_way(s, w);
                end else begin
                    exp_line.push_back(1'b0);
                    exp_addr.push_back(addr);
                    exp_wdata.push_back({{(LINE_W-WORD_W){1'b0}}, wdata});
                end
                exp_write.push_back(1'b1);
            end else if (hit) begin
                touch_way(s, w);
            end else begin
                w = pick_victim(s);
                m_valid[s][w] = 1'b1;
                m_tag[s][w] = t;
                touch_way(s, w);
                exp_write.push_back(1'b0);
                exp_line.push_back(1'b1);
                exp_addr.push_back(aligned);
                exp_wdata.push_back('0);
            end

            // The accepting edge opens the first cycle
            cycles = 1;
            do begin
                @(posedge clk);
                #1;
                cycles++;
            end while (!ready);

            if (!is_write) begin
                check_word("o_rdata", rdata, ref_mem[int'(addr[15:1])]);
            end
            if (!is_write && hit && cycles != 2) begin
                $display("Read hit at %0t took %0d cycles instead of 2", $time, cycles);
                other_errors++;
            end
            if (is_write && hit && free) begin
                check_flag("posted write ready at edge 2", cycles == 2, 1'b1);
                check_flag("posted write still open", done_count == done0, 1'b1);
            end
            compare_traffic();
        end

        // Let the last memory request finish
        while (act_addr.size() < exp_addr.size() || mem_read || mem_write) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        compare_traffic();
        if (act_addr.size() != 0 || exp_addr.size() != 0) begin
            $display("Memory request count differs: %0d extra seen, %0d missing",
                     act_addr.size(), exp_addr.size());
            other_errors++;
        end

        $display("Errors: word %0d, line %0d, addr %0d, flag %0d, other %0d, assert %0d",
                 word_errors, line_errors, addr_errors, flag_errors, other_errors,
                 i_dut.i_ctrl.i_props.assert_errors);
        if (word_errors + line_errors + addr_errors + flag_errors + other_errors
            + i_dut.i_ctrl.i_props.assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
cache_pkg.sv
cache_way.sv
cache_way_select.sv
cache_ctrl.sv
cache_top.sv
cache_properties.sv
tb_clk_gen.sv
tb_cache.sv

// File: Makefile
TOP := tb_cache

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
